// ==== common/avr_defs.svh ====
`ifndef AVR_DEFS_SVH
`define AVR_DEFS_SVH

// ------------------------------------------------------------
// Core widths
// ------------------------------------------------------------
`define AVR_DATA_W      8       // Register and data bus width
`define AVR_ADDR_W      16      // Program and data address width
`define AVR_INSN_W      16      // Instruction word
`define AVR_NREGS       32      // General registers

// X pointer pair
`define AVR_REG_XL      26
`define AVR_REG_XH      27

// ------------------------------------------------------------
// Opcode field positions
// ------------------------------------------------------------
`define AVR_RD_MSB      8       // Rd is opcode[8:4]
`define AVR_RD_LSB      4
`define AVR_RDI_MSB     7       // Upper-half Rd of immediate forms
`define AVR_RR_TOP      9       // Rr is {opcode[9], opcode[3:0]}
`define AVR_NIB_MSB     3       // Low nibble
`define AVR_KH_MSB      11      // High nibble of K
`define AVR_KH_LSB      8
`define AVR_RJMP_MSB    11      // RJMP offset is opcode[11:0]
`define AVR_BR_K_MSB    9       // Branch offset is opcode[9:3]
`define AVR_BR_K_LSB    3
`define AVR_BR_SENSE    10      // 0 for BRBS, 1 for BRBC
`define AVR_BR_BIT_MSB  2       // SREG bit select in opcode[2:0]
`define AVR_OFS_W       12      // Jump offset field in the decode struct

`endif

// ==== common/avr_pkg.sv ====
`default_nettype none

`include "avr_defs.svh"

package avr_pkg;

    typedef logic [`AVR_DATA_W-1:0]          data_t;
    typedef logic [`AVR_ADDR_W-1:0]          addr_t;
    typedef logic [$clog2(`AVR_NREGS)-1:0]   reg_idx_t;

    typedef enum logic [3:0] {
        ALU_PASS,   // Result is operand b
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,    // Also CP, SUBI, CPI
        ALU_SBC,    // Also CPC
        ALU_AND,
        ALU_OR,
        ALU_EOR
    } alu_op_e;

    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_RJMP,
        KIND_BRANCH,
        KIND_LD,
        KIND_ST,
        KIND_NOP
    } kind_e;

    // Same bit order as the SREG
    typedef struct packed {
        logic i;
        logic t;
        logic h;
        logic s;
        logic v;
        logic n;
        logic z;
        logic c;
    } sreg_t;

    typedef struct packed {
        alu_op_e                       alu_op;
        reg_idx_t                      rd;
        reg_idx_t                      rr;
        logic                          imm_valid;   // b operand from imm
        data_t                         imm;
        logic                          reg_we;
        logic                          flags_we;
        kind_e                         kind;
        logic                          x_inc;       // X+ form
        logic [2:0]                    br_bit;
        logic                          br_sense;
        logic signed [`AVR_OFS_W-1:0]  offset;      // RJMP or branch offset after sign extension
    } decoded_t;

    typedef struct packed {
        logic       reg_we;
        reg_idx_t   rd;
        data_t      data;
        logic       flags_we;
        sreg_t      flags;
        logic       x_inc;
    } wb_t;

endpackage

`default_nettype wire

// ==== exec/instr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

module instr_decode (
    input  wire [`AVR_INSN_W-1:0]   opcode_i,
    output avr_pkg::decoded_t       dec_o
);

    always_comb begin
        dec_o          = '0;
        dec_o.kind     = avr_pkg::KIND_NOP;
        dec_o.alu_op   = avr_pkg::ALU_PASS;
        dec_o.rd       = opcode_i[`AVR_RD_MSB:`AVR_RD_LSB];
        dec_o.rr       = {opcode_i[`AVR_RR_TOP], opcode_i[`AVR_NIB_MSB:0]};
        dec_o.imm      = {opcode_i[`AVR_KH_MSB:`AVR_KH_LSB], opcode_i[`AVR_NIB_MSB:0]};
        dec_o.br_bit   = opcode_i[`AVR_BR_BIT_MSB:0];
        dec_o.br_sense = ~opcode_i[`AVR_BR_SENSE];  // BRBS tests for a set bit

        casez (opcode_i)
            // Immediate ALU group with Rd in r16..r31
            16'b0011_????_????_????,
            16'b0101_????_????_????,
            16'b0110_????_????_????,
            16'b0111_????_????_????: begin
                dec_o.kind      = avr_pkg::KIND_ALU;
                dec_o.imm_valid = 1'b1;
                dec_o.rd        = {1'b1, opcode_i[`AVR_RDI_MSB:`AVR_RD_LSB]};
                dec_o.reg_we    = 1'b1;
                dec_o.flags_we  = 1'b1;
                case (opcode_i[14:12])
                    3'b011: begin                       // CPI
                        dec_o.alu_op = avr_pkg::ALU_SUB;
                        dec_o.reg_we = 1'b0;
                    end
                    3'b101:  dec_o.alu_op = avr_pkg::ALU_SUB;   // SUBI
                    3'b110:  dec_o.alu_op = avr_pkg::ALU_OR;    // ORI
                    default: dec_o.alu_op = avr_pkg::ALU_AND;   // ANDI
                endcase
            end

            // Two-register group
            16'b00??_????_????_????: begin
                dec_o.kind     = avr_pkg::KIND_ALU;
                dec_o.reg_we   = 1'b1;
                dec_o.flags_we = 1'b1;
                case (opcode_i[13:10])
                    4'b0001: begin                      // CPC
                        dec_o.alu_op = avr_pkg::ALU_SBC;
                        dec_o.reg_we = 1'b0;
                    end
                    4'b0010: dec_o.alu_op = avr_pkg::ALU_SBC;
                    4'b0011: dec_o.alu_op = avr_pkg::ALU_ADD;
                    4'b0101: begin                      // CP
                        dec_o.alu_op = avr_pkg::ALU_SUB;
                        dec_o.reg_we = 1'b0;
                    end
                    4'b0110: dec_o.alu_op = avr_pkg::ALU_SUB;
                    4'b0111: dec_o.alu_op = avr_pkg::ALU_ADC;
                    4'b1000: dec_o.alu_op = avr_pkg::ALU_AND;
                    4'b1001: dec_o.alu_op = avr_pkg::ALU_EOR;
                    4'b1010: dec_o.alu_op = avr_pkg::ALU_OR;
                    4'b1011: dec_o.flags_we = 1'b0;     // MOV
                    default: begin                      // NOP and dropped forms
                        dec_o.kind     = avr_pkg::KIND_NOP;
                        dec_o.reg_we   = 1'b0;
                        dec_o.flags_we = 1'b0;
                    end
                endcase
            end

            16'b1110_????_????_????: begin              // LDI
                dec_o.kind      = avr_pkg::KIND_ALU;
                dec_o.imm_valid = 1'b1;
                dec_o.rd        = {1'b1, opcode_i[`AVR_RDI_MSB:`AVR_RD_LSB]};
                dec_o.reg_we    = 1'b1;
            end

            16'b1100_????_????_????: begin              // RJMP
                dec_o.kind   = avr_pkg::KIND_RJMP;
                dec_o.offset = opcode_i[`AVR_RJMP_MSB:0];
            end

            16'b1111_0???_????_????: begin              // BRBS, BRBC
                dec_o.kind   = avr_pkg::KIND_BRANCH;
                dec_o.offset = {{(`AVR_OFS_W - (`AVR_BR_K_MSB - `AVR_BR_K_LSB + 1))
                                 {opcode_i[`AVR_BR_K_MSB]}},
                                opcode_i[`AVR_BR_K_MSB:`AVR_BR_K_LSB]};
            end

            16'b1001_000?_????_110?: begin              // LD Rd, X / X+
                dec_o.kind   = avr_pkg::KIND_LD;
                dec_o.reg_we = 1'b1;
                dec_o.x_inc  = opcode_i[0];
            end

            16'b1001_001?_????_110?: begin              // ST X / X+, Rr
                dec_o.kind  = avr_pkg::KIND_ST;
                dec_o.x_inc = opcode_i[0];
            end

            default: ;                                  // Executes as NOP
        endcase
    end

endmodule

`default_nettype wire

// ==== exec/exec_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

module exec_ctrl (
    input  wire                     clock_i,
    input  wire                     reset_n_i,
    input  wire [`AVR_INSN_W-1:0]   ir_i,
    input  wire avr_pkg::data_t     data_i,
    input  wire avr_pkg::decoded_t  dec_i,
    input  wire avr_pkg::data_t     rd_data_i,
    input  wire avr_pkg::data_t     rr_data_i,
    input  wire avr_pkg::addr_t     x_ptr_i,
    input  wire avr_pkg::sreg_t     sreg_i,
    input  wire avr_pkg::data_t     alu_result_i,
    input  wire avr_pkg::sreg_t     alu_flags_i,
    output avr_pkg::addr_t          pc_o,
    output logic [`AVR_INSN_W-1:0]  decode_word_o,
    output avr_pkg::alu_op_e        alu_op_o,
    output avr_pkg::data_t          alu_a_o,
    output avr_pkg::data_t          alu_b_o,
    output avr_pkg::wb_t            wb_o,
    output avr_pkg::addr_t          address_o,
    output avr_pkg::data_t          data_o,
    output logic                    we_o
);

    avr_pkg::addr_t         pc_q;
    avr_pkg::addr_t         pc_inc;
    avr_pkg::addr_t         pc_jump;
    avr_pkg::addr_t         pc_next;
    logic                   ld_q;           // Second cycle of LD
    logic [`AVR_INSN_W-1:0] latch_q;        // Opcode held across LD
    avr_pkg::addr_t         address_q;
    avr_pkg::data_t         data_q;
    logic                   we_q;
    logic                   branch_taken;
    logic                   mem_op;

    assign decode_word_o = ld_q ? latch_q : ir_i;

    assign alu_op_o = dec_i.alu_op;
    assign alu_a_o  = rd_data_i;
    assign alu_b_o  = dec_i.imm_valid ? dec_i.imm : rr_data_i;

    // ------------------------------------------------------------
    // Next pc
    // ------------------------------------------------------------
    assign pc_inc       = pc_q + 1'b1;
    assign pc_jump      = pc_inc + {{(`AVR_ADDR_W - `AVR_OFS_W){dec_i.offset[`AVR_OFS_W-1]}},
                                    dec_i.offset};
    assign branch_taken = (sreg_i[dec_i.br_bit] == dec_i.br_sense);

    always_comb begin
        pc_next = pc_inc;
        if (ld_q) begin
            pc_next = pc_q;                     // Already advanced in cycle 0
        end else if (dec_i.kind == avr_pkg::KIND_RJMP) begin
            pc_next = pc_jump;
        end else if (dec_i.kind == avr_pkg::KIND_BRANCH && branch_taken) begin
            pc_next = pc_jump;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_n_i) begin
            pc_q <= '0;
            ld_q <= 1'b0;
            we_q <= 1'b0;
        end else begin
            pc_q <= pc_next;
            ld_q <= !ld_q && dec_i.kind == avr_pkg::KIND_LD;
            we_q <= !ld_q && dec_i.kind == avr_pkg::KIND_ST;   // One-cycle pulse
        end
    end

    // ------------------------------------------------------------
    // Data memory side
    // ------------------------------------------------------------
    assign mem_op = !ld_q && (dec_i.kind == avr_pkg::KIND_LD || dec_i.kind == avr_pkg::KIND_ST);

    always_ff @(posedge clock_i) begin
        if (!ld_q) begin
            latch_q <= ir_i;
        end
        if (mem_op) begin
            address_q <= x_ptr_i;               // X before any post-increment
        end
        if (!ld_q && dec_i.kind == avr_pkg::KIND_ST) begin
            data_q <= rd_data_i;
        end
    end

    assign address_o = address_q;
    assign data_o    = data_q;
    assign we_o      = we_q;

    // LD data reaches write-back in its second cycle
    always_comb begin
        wb_o          = '0;
        wb_o.rd       = dec_i.rd;
        wb_o.data     = ld_q ? data_i : alu_result_i;
        wb_o.reg_we   = dec_i.reg_we && (ld_q || dec_i.kind == avr_pkg::KIND_ALU);
        wb_o.flags_we = dec_i.flags_we;
        wb_o.flags    = alu_flags_i;
        wb_o.x_inc    = mem_op && dec_i.x_inc;
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== exec/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

module alu (
    input  wire avr_pkg::alu_op_e   op_i,
    input  wire avr_pkg::data_t     a_i,
    input  wire avr_pkg::data_t     b_i,
    input  wire avr_pkg::sreg_t     sreg_i,
    output avr_pkg::data_t          result_o,
    output avr_pkg::sreg_t          flags_o
);

    localparam int MSB = `AVR_DATA_W - 1;

    logic                   carry_in;
    logic [`AVR_DATA_W:0]   add_w;      // Carry in top bit
    logic [`AVR_DATA_W:0]   sub_w;      // Borrow in top bit
    avr_pkg::data_t         add_r;
    avr_pkg::data_t         sub_r;
    logic                   add_h;
    logic                   add_v;
    logic                   sub_h;
    logic                   sub_v;

    assign carry_in = (op_i == avr_pkg::ALU_ADC || op_i == avr_pkg::ALU_SBC) ? sreg_i.c : 1'b0;

    assign add_w = {1'b0, a_i} + {1'b0, b_i} + {{`AVR_DATA_W{1'b0}}, carry_in};
    assign sub_w = {1'b0, a_i} - {1'b0, b_i} - {{`AVR_DATA_W{1'b0}}, carry_in};
    assign add_r = add_w[MSB:0];
    assign sub_r = sub_w[MSB:0];

    // ------------------------------------------------------------
    // Half carry and overflow
    // ------------------------------------------------------------
    assign add_h = (a_i[3] & b_i[3]) | (b_i[3] & ~add_r[3]) | (~add_r[3] & a_i[3]);
    assign add_v = (a_i[MSB] & b_i[MSB] & ~add_r[MSB]) | (~a_i[MSB] & ~b_i[MSB] & add_r[MSB]);
    assign sub_h = (~a_i[3] & b_i[3]) | (b_i[3] & sub_r[3]) | (sub_r[3] & ~a_i[3]);
    assign sub_v = (a_i[MSB] & ~b_i[MSB] & ~sub_r[MSB]) | (~a_i[MSB] & b_i[MSB] & sub_r[MSB]);

    always_comb begin
        result_o = b_i;
        flags_o  = sreg_i;
        case (op_i)
            avr_pkg::ALU_ADD, avr_pkg::ALU_ADC: begin
                result_o  = add_r;
                flags_o.h = add_h;
                flags_o.v = add_v;
                flags_o.c = add_w[`AVR_DATA_W];
            end
            avr_pkg::ALU_SUB, avr_pkg::ALU_SBC: begin
                result_o  = sub_r;
                flags_o.h = sub_h;
                flags_o.v = sub_v;
                flags_o.c = sub_w[`AVR_DATA_W];     // Borrow out when a < b plus carry in
            end
            avr_pkg::ALU_AND: begin
                result_o  = a_i & b_i;
                flags_o.v = 1'b0;
            end
            avr_pkg::ALU_OR: begin
                result_o  = a_i | b_i;
                flags_o.v = 1'b0;
            end
            avr_pkg::ALU_EOR: begin
                result_o  = a_i ^ b_i;
                flags_o.v = 1'b0;
            end
            default: result_o = b_i;                // PASS for MOV and LDI
        endcase

        if (op_i != avr_pkg::ALU_PASS) begin
            flags_o.n = result_o[MSB];
            // SBC and CPC chain Z over a multi-byte compare
            flags_o.z = (result_o == '0) && (op_i != avr_pkg::ALU_SBC || sreg_i.z);
            flags_o.s = flags_o.n ^ flags_o.v;
        end
        flags_o.i = 1'b0;                           // No interrupts
        flags_o.t = 1'b0;                           // No BST
    end

endmodule

`default_nettype wire

// ==== hdl/gpr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

module gpr_file (
    input  wire                     clock_i,
    input  wire                     reset_n_i,
    input  wire avr_pkg::reg_idx_t  rd_idx_i,
    input  wire avr_pkg::reg_idx_t  rr_idx_i,
    output avr_pkg::data_t          rd_data_o,
    output avr_pkg::data_t          rr_data_o,
    output avr_pkg::addr_t          x_ptr_o,
    output avr_pkg::sreg_t          sreg_o,
    input  wire avr_pkg::wb_t       wb_i
);

    avr_pkg::data_t regs_q [`AVR_NREGS];
    avr_pkg::sreg_t sreg_q;

    assign rd_data_o = regs_q[rd_idx_i];
    assign rr_data_o = regs_q[rr_idx_i];
    assign x_ptr_o   = {regs_q[`AVR_REG_XH], regs_q[`AVR_REG_XL]};
    assign sreg_o    = sreg_q;

    // ------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------
    always_ff @(posedge clock_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < `AVR_NREGS; i++) begin
                regs_q[i] <= '0;
            end
            sreg_q <= '0;
        end else begin
            if (wb_i.reg_we) begin
                regs_q[wb_i.rd] <= wb_i.data;
            end
            // Post-increment wins over a write to r26 or r27
            if (wb_i.x_inc) begin
                {regs_q[`AVR_REG_XH], regs_q[`AVR_REG_XL]} <= x_ptr_o + 1'b1;
            end
            if (wb_i.flags_we) begin
                sreg_q <= wb_i.flags;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/avr_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

module avr_core (
    input  wire                     clock_i,
    input  wire                     reset_n_i,
    // Program memory
    output avr_pkg::addr_t          pc_o,
    input  wire [`AVR_INSN_W-1:0]   ir_i,       // Word at pc_o in the same cycle
    // Data memory
    output avr_pkg::addr_t          address_o,
    input  wire avr_pkg::data_t     data_i,     // Byte at address_o in the same cycle
    output avr_pkg::data_t          data_o,
    output logic                    we_o
);

    logic [`AVR_INSN_W-1:0] decode_word;
    avr_pkg::decoded_t      dec;
    avr_pkg::data_t         rd_data;
    avr_pkg::data_t         rr_data;
    avr_pkg::addr_t         x_ptr;
    avr_pkg::sreg_t         sreg;
    avr_pkg::alu_op_e       alu_op;
    avr_pkg::data_t         alu_a;
    avr_pkg::data_t         alu_b;
    avr_pkg::data_t         alu_result;
    avr_pkg::sreg_t         alu_flags;
    avr_pkg::wb_t           wb;

    instr_decode u_decode (
        .opcode_i   (decode_word),
        .dec_o      (dec)
    );

    exec_ctrl u_exec (
        .clock_i        (clock_i),
        .reset_n_i      (reset_n_i),
        .ir_i           (ir_i),
        .data_i         (data_i),
        .dec_i          (dec),
        .rd_data_i      (rd_data),
        .rr_data_i      (rr_data),
        .x_ptr_i        (x_ptr),
        .sreg_i         (sreg),
        .alu_result_i   (alu_result),
        .alu_flags_i    (alu_flags),
        .pc_o           (pc_o),
        .decode_word_o  (decode_word),
        .alu_op_o       (alu_op),
        .alu_a_o        (alu_a),
        .alu_b_o        (alu_b),
        .wb_o           (wb),
        .address_o      (address_o),
        .data_o         (data_o),
        .we_o           (we_o)
    );

    alu u_alu (
        .op_i       (alu_op),
        .a_i        (alu_a),
        .b_i        (alu_b),
        .sreg_i     (sreg),
        .result_o   (alu_result),
        .flags_o    (alu_flags)
    );

    gpr_file u_gpr (
        .clock_i    (clock_i),
        .reset_n_i  (reset_n_i),
        .rd_idx_i   (dec.rd),
        .rr_idx_i   (dec.rr),
        .rd_data_o  (rd_data),
        .rr_data_o  (rr_data),
        .x_ptr_o    (x_ptr),
        .sreg_o     (sreg),
        .wb_i       (wb)
    );

endmodule

`default_nettype wire

// ==== dv/avr_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

module avr_chk (
    input  wire                     clock_i,
    input  wire                     reset_n_i,
    input  wire avr_pkg::addr_t     pc_o,
    input  wire [`AVR_INSN_W-1:0]   ir_i,
    input  wire                     we_o
);

    logic ld_first;     // LD in its first cycle
    logic ld_second;

    assign ld_first = reset_n_i && !ld_second
                      && ir_i[15:9] == 7'b1001000 && ir_i[3:1] == 3'b110;

    always_ff @(posedge clock_i) begin
        if (!reset_n_i) begin
            ld_second <= 1'b0;
        end else begin
            ld_second <= ld_first;
        end
    end

    // ------------------------------------------------------------
    // Port rules
    // ------------------------------------------------------------
    we_after_reset: assert property (@(posedge clock_i) !reset_n_i |=> !we_o)
        else $error("we_o high in the cycle after reset");

    // pc holds while the LD data is written back
    pc_hold_on_ld: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        ld_first |-> ##2 $stable(pc_o))
        else $error("pc_o moved during the second LD cycle");

endmodule

`default_nettype wire

// ==== dv/avr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "avr_defs.svh"

bind avr_core avr_chk u_chk (
    .clock_i    (clock_i),
    .reset_n_i  (reset_n_i),
    .pc_o       (pc_o),
    .ir_i       (ir_i),
    .we_o       (we_o)
);

module avr_tb;

    localparam int N_INSN = 200;
    localparam int LIMIT  = 2 * N_INSN + 20;
    // Instruction classes of the generator
    localparam int K_ALU2 = 1, K_IMM = 2, K_LDI = 3;
    localparam int K_RJMP = 4, K_BR = 5, K_LD = 6, K_ST = 7;
    // ALU operations of the generator
    localparam int OP_ADD = 0, OP_ADC = 1, OP_SUB = 2, OP_SBC = 3, OP_AND = 4;
    localparam int OP_OR = 5, OP_EOR = 6, OP_MOV = 7, OP_CP = 8, OP_CPC = 9;
    localparam int F_C = 0, F_Z = 1, F_N = 2, F_V = 3, F_S = 4, F_H = 5;

    logic                   clock;
    logic                   reset_n;
    avr_pkg::addr_t         pc_o;
    logic [15:0]            ir_i;
    avr_pkg::addr_t         address_o;
    avr_pkg::data_t         data_i;
    avr_pkg::data_t         data_o;
    logic                   we_o;

    logic [15:0]            prog [256];
    avr_pkg::data_t         dmem [256];
    int                     p_kind [N_INSN];
    int                     p_op [N_INSN];
    int                     p_rd [N_INSN];
    int                     p_rr [N_INSN];
    int                     p_k [N_INSN];
    integer                 seed;
    logic [7:0]             m_regs [32];
    logic [7:0]             m_mem [256];
    logic [7:0]             m_sreg;
    int                     m_pc;
    logic                   m_ld;
    int                     ld_rd;
    logic [15:0]            ld_addr;
    logic [23:0]            st_q [$];
    int                     cycles;
    logic                   done;

    avr_core dut_i (
        .clock_i    (clock),
        .reset_n_i  (reset_n),
        .pc_o       (pc_o),
        .ir_i       (ir_i),
        .address_o  (address_o),
        .data_i     (data_i),
        .data_o     (data_o),
        .we_o       (we_o)
    );

    always #5 clock = ~clock;

    // Memory models read in the same cycle
    assign ir_i   = prog[pc_o[7:0]];
    assign data_i = dmem[address_o[7:0]];

    always @(posedge clock) begin
        if (we_o) begin
            dmem[address_o[7:0]] <= data_o;
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_addr(input string name, input avr_pkg::addr_t got,
                              input avr_pkg::addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_byte(input string name, input avr_pkg::data_t got,
                              input avr_pkg::data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_pc(input avr_pkg::addr_t got, input avr_pkg::addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: pc_o got %h expected %h", got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on pc_o");
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", msg);
    endtask

    // ------------------------------------------------------------
    // Program generator
    // ------------------------------------------------------------
    function automatic logic [15:0] encode(input int kind, input int op, input int rd,
                                           input int rr, input int k);
        logic [3:0] opc;
        logic [4:0] d;
        logic [4:0] r;
        logic [7:0] kk;
        d  = rd[4:0];
        r  = rr[4:0];
        kk = k[7:0];
        case (op)
            OP_ADD:  opc = (kind == K_IMM) ? 4'b0000 : 4'b0011;
            OP_ADC:  opc = 4'b0111;
            OP_SUB:  opc = (kind == K_IMM) ? 4'b0101 : 4'b0110;
            OP_SBC:  opc = 4'b0010;
            OP_AND:  opc = (kind == K_IMM) ? 4'b0111 : 4'b1000;
            OP_OR:   opc = (kind == K_IMM) ? 4'b0110 : 4'b1010;
            OP_EOR:  opc = 4'b1001;
            OP_MOV:  opc = 4'b1011;
            OP_CP:   opc = (kind == K_IMM) ? 4'b0011 : 4'b0101;
            default: opc = 4'b0001;             // CPC
        endcase
        case (kind)
            K_ALU2:  encode = {2'b00, opc, r[4], d, r[3:0]};
            K_IMM:   encode = {opc, kk[7:4], d[3:0], kk[3:0]};
            K_LDI:   encode = {4'b1110, kk[7:4], d[3:0], kk[3:0]};
            K_RJMP:  encode = {4'b1100, k[11:0]};
            K_BR:    encode = {5'b11110, op[0], k[6:0], rr[2:0]};   // op 1 is BRBC
            K_LD:    encode = {7'b1001000, d, 3'b110, op[0]};
            K_ST:    encode = {7'b1001001, r, 3'b110, op[0]};
            default: encode = 16'h0000;
        endcase
    endfunction

    task automatic set_insn(input int i, input int kind, input int op, input int rd,
                            input int rr, input int k);
        p_kind[i] = kind;
        p_op[i]   = op;
        p_rd[i]   = rd;
        p_rr[i]   = rr;
        p_k[i]    = k;
        prog[i]   = encode(kind, op, rd, rr, k);
    endtask

    function automatic int rnd(input int n);
        rnd = {$random(seed)} % n;
    endfunction

    task automatic build_program();
        int sel;
        int span;
        int imm_ops [4];
        imm_ops = '{OP_SUB, OP_AND, OP_OR, OP_CP};
        for (int a = 0; a < 256; a++) begin
            prog[a] = 16'h0000;
        end
        set_insn(0, K_LDI, 0, `AVR_REG_XL, 0, rnd(256));
        set_insn(1, K_LDI, 0, `AVR_REG_XH, 0, 0);
        for (int i = 2; i < N_INSN - 1; i++) begin
            sel  = rnd(16);
            span = (N_INSN - 2 - i < 8) ? N_INSN - 1 - i : 8;  // Targets stay ahead
            if (sel < 6) begin
                set_insn(i, K_ALU2, rnd(10), rnd(26), rnd(32), 0);
            end else if (sel < 8) begin
                set_insn(i, K_IMM, imm_ops[rnd(4)], 16 + rnd(10), 0, rnd(256));
            end else if (sel == 8) begin
                set_insn(i, K_LDI, 0, 16 + rnd(10), 0, rnd(256));
            end else if (sel == 9) begin
                set_insn(i, K_LDI, 0, `AVR_REG_XL, 0, rnd(256));    // New X
            end else if (sel == 10) begin
                set_insn(i, K_BR, rnd(2), 0, rnd(8), rnd(span));
            end else if (sel == 11) begin
                set_insn(i, K_RJMP, 0, 0, 0, rnd(span));
            end else if (sel < 14) begin
                set_insn(i, K_LD, rnd(2), rnd(26), 0, 0);
            end else begin
                set_insn(i, K_ST, rnd(2), 0, rnd(32), 0);
            end
        end
        set_insn(N_INSN - 1, K_RJMP, 0, 0, 0, -1);              // Self-loop
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    task automatic model_alu(input int op, input logic [7:0] a, input logic [7:0] b,
                             output logic [7:0] r);
        int cin;
        int sa;
        int sb;
        int sv;
        cin = (op == OP_ADC || op == OP_SBC || op == OP_CPC) ? int'(m_sreg[F_C]) : 0;
        sa  = int'($signed(a));
        sb  = int'($signed(b));
        r   = b;
        if (op == OP_ADD || op == OP_ADC) begin
            r = 8'(int'(a) + int'(b) + cin);
            m_sreg[F_C] = (int'(a) + int'(b) + cin) > 255;
            m_sreg[F_H] = (int'(a[3:0]) + int'(b[3:0]) + cin) > 15;
            sv = sa + sb + cin;
            m_sreg[F_V] = sv > 127 || sv < -128;
        end else if (op == OP_SUB || op == OP_SBC || op == OP_CP || op == OP_CPC) begin
            r = 8'(int'(a) - int'(b) - cin);
            m_sreg[F_C] = int'(a) < int'(b) + cin;
            m_sreg[F_H] = int'(a[3:0]) < int'(b[3:0]) + cin;
            sv = sa - sb - cin;
            m_sreg[F_V] = sv > 127 || sv < -128;
        end else if (op != OP_MOV) begin
            r = (op == OP_AND) ? (a & b) : (op == OP_OR) ? (a | b) : (a ^ b);
            m_sreg[F_V] = 1'b0;
        end
        if (op != OP_MOV) begin
            m_sreg[F_Z] = (r == 8'h00) && ((op != OP_SBC && op != OP_CPC) || m_sreg[F_Z]);
            m_sreg[F_N] = r[7];
            m_sreg[F_S] = m_sreg[F_N] ^ m_sreg[F_V];
        end
    endtask

    task automatic model_step();
        logic [7:0]  r;
        logic [15:0] x;
        int          pc;
        pc = m_pc;
        x  = {m_regs[`AVR_REG_XH], m_regs[`AVR_REG_XL]};
        if (m_ld) begin
            m_regs[ld_rd] = m_mem[ld_addr[7:0]];    // pc holds
            m_ld = 1'b0;
            return;
        end
        m_pc = pc + 1;
        case (p_kind[pc])
            K_ALU2, K_IMM: begin
                model_alu(p_op[pc], m_regs[p_rd[pc]],
                          (p_kind[pc] == K_IMM) ? 8'(p_k[pc]) : m_regs[p_rr[pc]], r);
                if (p_op[pc] != OP_CP && p_op[pc] != OP_CPC) begin
                    m_regs[p_rd[pc]] = r;
                end
            end
            K_LDI:  m_regs[p_rd[pc]] = 8'(p_k[pc]);
            K_RJMP: m_pc = pc + 1 + p_k[pc];
            K_BR: begin
                if (m_sreg[p_rr[pc]] == !p_op[pc][0]) begin
                    m_pc = pc + 1 + p_k[pc];
                end
            end
            K_LD, K_ST: begin
                if (p_kind[pc] == K_LD) begin
                    ld_addr = x;
                    ld_rd   = p_rd[pc];
                    m_ld    = 1'b1;
                end else begin
                    st_q.push_back({x, m_regs[p_rr[pc]]});
                    m_mem[x[7:0]] = m_regs[p_rr[pc]];
                end
                if (p_op[pc][0]) begin
                    {m_regs[`AVR_REG_XH], m_regs[`AVR_REG_XL]} = x + 16'd1;
                end
            end
            default: ;
        endcase
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [23:0] st;
        clock   = 1'b0;
        reset_n = 1'b0;
        seed    = 32'h401d_8c71;
        build_program();
        for (int a = 0; a < 256; a++) begin
            dmem[a]  = 8'(a * 37 + (a >> 3)) ^ 8'ha5;
            m_mem[a] = 8'(a * 37 + (a >> 3)) ^ 8'ha5;
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 8'h00;
        end
        m_sreg = 8'h00;
        m_pc   = 0;
        m_ld   = 1'b0;
        cycles = 0;
        done   = 1'b0;

        @(posedge clock);
        @(negedge clock);
        check_pc(pc_o, 16'h0000);
        if (we_o !== 1'b0) begin
            report_error("we_o is not low during reset");
        end
        @(posedge clock);
        reset_n <= 1'b1;

        while (!done && cycles < LIMIT) begin
            @(negedge clock);
            cycles++;
            check_pc(pc_o, 16'(m_pc));
            if (we_o === 1'b1) begin
                if (st_q.size() == 0) begin
                    report_error("Store seen on we_o with none expected");
                end
                st = st_q.pop_front();
                check_addr("address_o", address_o, st[23:8]);
                check_byte("data_o", data_o, st[7:0]);
            end else if (st_q.size() != 0) begin
                report_error("Expected store did not appear on we_o");
            end
            if (m_pc == N_INSN - 1 && !m_ld && st_q.size() == 0) begin
                done = 1'b1;
            end else begin
                model_step();
            end
        end

        if (done) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Timeout: self-loop not reached within %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/avr_pkg.sv
exec/instr_decode.sv
exec/exec_ctrl.sv
exec/alu.sv
hdl/gpr_file.sv
hdl/avr_core.sv
dv/avr_chk.sv
dv/avr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the AVR core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f sim.f --top-module avr_tb -o avr_sim &&
./obj_dir/avr_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
